// ==== list.f ====
logic/jtframe_pkg.sv
logic/jtframe_sdram.sv
logic/jtframe_board.sv
logic/jtframe_hps_io.sv
logic/jtframe_mister.sv
verif/sdram_model.sv
verif/jtframe_mister_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= jtframe_mister_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/jtframe_mister_tb.sv ====
`timescale 1ns/1ps

module jtframe_mister_tb;

    localparam int INIT_WAIT = 20;
    localparam int NBYTES    = 64;
    localparam int LIMIT     = INIT_WAIT + 2 + 2 * jtframe_pkg::T_RC + 20   // Power-up
                               + NBYTES * 14                                // Download
                               + 24 * 30 + 400                              // Reads, refresh
                               + 1500;                                      // Margin

    logic clk_sys = 1'b0;
    logic rst_n, rst_req, refresh_en, sdram_req;
    logic [21:0] sdram_addr;
    jtframe_pkg::hps_bus_t    hps_bus;
    jtframe_pkg::status_t     status;
    jtframe_pkg::dip_t        dip;
    jtframe_pkg::sdram_pins_t sdram_pins;
    wire  [15:0] sdram_dq;
    logic        downloading, ioctl_wr, prog_we, sdram_ack, data_rdy, loop_rst;
    logic        game_rst, led, flip_prev, cause;
    logic [21:0] ioctl_addr, prog_addr;
    logic [7:0]  ioctl_data, prog_data;
    logic [1:0]  prog_mask, game_coin, game_start;
    logic [31:0] data_read, rnd = 32'h49be;
    logic [6:0]  game_joystick1, game_joystick2;
    logic [4:0]  quiet;            // Samples since the last reset cause
    logic [7:0]  rom [NBYTES];
    int          errors = 0, cycles = 0, wr_seen = 0, mark;

    always #5 clk_sys = ~clk_sys;

    // Download loopback, byte replicated on both lanes
    assign prog_addr = ioctl_addr;
    assign prog_data = ioctl_data;
    assign prog_mask = ioctl_addr[0] ? 2'b01 : 2'b10;
    assign prog_we   = ioctl_wr;

    jtframe_mister #(.THREE_BUTTONS(1'b0), .GAME_INPUTS_ACTIVE_LOW(1'b1),
                     .INIT_WAIT(INIT_WAIT)) jtframe_mister_inst (.*);

    sdram_model u_model (.clk(clk_sys), .pins(sdram_pins), .dq(sdram_dq));

    assign cause = loop_rst || downloading || rst_req || status.reset ||
                   (status.flip != flip_prev);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            flip_prev <= 1'b0;
            quiet     <= '0;
        end else begin
            flip_prev <= status.flip;
            quiet     <= cause ? 5'd0 : (quiet == 5'd31 ? quiet : quiet + 5'd1);
        end
    end

    function automatic jtframe_pkg::dip_t dip_of(input jtframe_pkg::status_t s);
        jtframe_pkg::dip_t d;
        d = '{test: s.test, pause: s.pause, flip: s.flip, service: s.service,
              fxlevel: s.fxlevel, scanlines: s.scanlines, force_scan2x: s.force_scan2x,
              rotate: s.rotate, en_mixing: s.en_mixing};
        return d;
    endfunction

    assert property (@(posedge clk_sys) disable iff (!rst_n) !cause |-> game_rst == (quiet < 16))
        else begin
            $display("FAILED at %0t: game_rst = %b, expected %b", $time,
                     $sampled(game_rst), $sampled(quiet) < 16);
            errors++;
        end
    assert property (@(posedge clk_sys) disable iff (!rst_n) dip == dip_of($past(status)))
        else begin
            $display("FAILED at %0t: dip = %h, expected %h", $time,
                     $sampled(dip), dip_of($past(status)));
            errors++;
        end
    assert property (@(posedge clk_sys) disable iff (!rst_n) data_rdy == $past(sdram_ack, 6))
        else begin
            $display("data_rdy at %0t is not 6 cycles after sdram_ack", $time);
            errors++;
        end
    assert property (@(posedge clk_sys) disable iff (!rst_n) ioctl_wr |-> downloading && led)
        else begin
            $display("ioctl_wr at %0t while downloading or led is low", $time);
            errors++;
        end

    task automatic expect_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, sig, got, exp);
            errors++;
        end
    endtask

    always @(posedge clk_sys) begin
        if (rst_n && ioctl_wr) begin
            expect_value("ioctl_addr", 32'(ioctl_addr), 32'(wr_seen));
            expect_value("ioctl_data", 32'(ioctl_data), 32'(rom[wr_seen % NBYTES]));
            wr_seen++;
        end
    end

    always @(posedge clk_sys) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rnd = rnd ^ (rnd << 13);
        rnd = rnd ^ (rnd >> 17);
        rnd = rnd ^ (rnd << 5);
        return rnd;
    endfunction

    task automatic strobe_word(input logic [15:0] w);
        @(posedge clk_sys);
        hps_bus.io_strobe <= 1'b1;
        hps_bus.io_din    <= w;
        @(posedge clk_sys);
        hps_bus.io_strobe <= 1'b0;
    endtask

    task automatic open_command(input logic [7:0] code);
        @(posedge clk_sys);
        hps_bus.io_enable <= 1'b1;
        strobe_word({8'h00, code});
    endtask

    task automatic close_command();
        @(posedge clk_sys);
        hps_bus.io_enable <= 1'b0;
        repeat (2) @(posedge clk_sys);
    endtask

    task automatic send_status(input logic [31:0] w);
        open_command(jtframe_pkg::CMD_STATUS);
        strobe_word(w[15:0]);
        strobe_word(w[31:16]);
        close_command();
    endtask

    task automatic wait_game_release();
        while (game_rst) @(posedge clk_sys);
    endtask

    task automatic read_and_check(input logic [21:0] a);
        int n;
        int b;
        b = 2 * int'(a);
        @(posedge clk_sys);
        sdram_req  <= 1'b1;
        sdram_addr <= a;
        n = 0;
        do begin
            @(posedge clk_sys);
            n++;
        end while (!sdram_ack && n < 64);
        if (!sdram_ack) begin
            $display("No sdram_ack for address %h", a);
            errors++;
        end
        sdram_req <= 1'b0;
        while (!data_rdy) @(posedge clk_sys);
        expect_value("data_read", data_read, {rom[b+3], rom[b+2], rom[b+1], rom[b]});
    endtask

    task automatic report(input int n, input string name);
        $display("[%0d] %s finished, %0d new errors", n, name, errors - mark);
        mark = errors;
    endtask

    initial begin
        logic [31:0] r;
        int          refs;
        hps_bus    = '0;
        rst_n      = 1'b0;
        rst_req    = 1'b0;
        refresh_en = 1'b0;
        sdram_req  = 1'b0;
        sdram_addr = '0;
        mark       = 0;
        for (int i = 0; i < NBYTES; i++) begin
            r = next_rand();
            rom[i] = r[7:0];
        end
        repeat (4) @(posedge clk_sys);
        rst_n <= 1'b1;

        @(negedge clk_sys);
        expect_value("loop_rst", 32'(loop_rst), 1);
        expect_value("game_rst", 32'(game_rst), 1);
        expect_value("sdram_ack", 32'(sdram_ack), 0);
        expect_value("data_rdy", 32'(data_rdy), 0);
        expect_value("ioctl_wr", 32'(ioctl_wr), 0);
        expect_value("downloading", 32'(downloading), 0);
        while (loop_rst) @(posedge clk_sys);
        wait_game_release();
        report(1, "reset release");

        r = next_rand();
        open_command(jtframe_pkg::CMD_JOY0);
        strobe_word(r[15:0]);
        close_command();
        open_command(jtframe_pkg::CMD_JOY1);
        strobe_word(r[31:16]);
        close_command();
        @(negedge clk_sys);
        expect_value("game_joystick1", 32'(game_joystick1), {25'd0, ~{1'b0, r[5:0]}});
        expect_value("game_joystick2", 32'(game_joystick2), {25'd0, ~{1'b0, r[21:16]}});
        expect_value("game_coin", 32'(game_coin), {30'd0, ~{r[24], r[8]}});
        expect_value("game_start", 32'(game_start), {30'd0, ~{r[25], r[9]}});
        report(2, "joysticks");

        r = next_rand();
        r[1:0] = 2'b10;                 // Flip change alone
        send_status(r);
        @(negedge clk_sys);
        expect_value("status", status, r);
        expect_value("game_rst", 32'(game_rst), 1);
        wait_game_release();
        r[0] = 1'b1;                    // Status reset
        send_status(r);
        @(negedge clk_sys);
        expect_value("game_rst", 32'(game_rst), 1);
        r[0] = 1'b0;
        send_status(r);
        wait_game_release();
        report(3, "status word");

        open_command(jtframe_pkg::CMD_DL_START);
        for (int i = 0; i < NBYTES; i++) begin
            strobe_word({8'h00, rom[i]});
            repeat (10) @(posedge clk_sys);
        end
        close_command();
        open_command(jtframe_pkg::CMD_DL_END);
        close_command();
        wait_game_release();
        expect_value("write count", 32'(wr_seen), NBYTES);
        expect_value("led", 32'(led), 0);
        report(4, "download");

        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            read_and_check(22'(2 * (r % 16)));
        end
        report(5, "reads");

        refs = u_model.refresh_count;
        @(posedge clk_sys);
        refresh_en <= 1'b1;
        repeat (200) @(posedge clk_sys);
        assert (u_model.refresh_count > refs) else begin
            $display("Refresh count did not rise with refresh_en high");
            errors++;
        end
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            read_and_check(22'(2 * (r % 16)));
            repeat (r[7:4] * 4) @(posedge clk_sys);
        end
        report(6, "refresh");

        errors = errors + u_model.errors;
        $display("Checks done: %0d errors, %0d SDRAM model errors", errors, u_model.errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model (
    input  logic                     clk,
    input  jtframe_pkg::sdram_pins_t pins,
    inout  wire  [15:0]              dq
);

    logic [15:0] mem [int];             // Keyed by {row, column}
    logic [12:0] row_open [4];
    logic [15:0] dq_out;
    logic        dq_oe = 1'b0;
    logic [1:0]  rd_stage = 2'd0;
    logic [1:0]  rd_ba;
    logic [8:0]  rd_col;
    int          refresh_count = 0;
    int          errors = 0;
    int          since_rc = jtframe_pkg::T_RC;      // Cycles since ACTIVE or REFRESH
    int          since_act = jtframe_pkg::T_RCD;
    logic [2:0]  cmd;
    logic        valid, is_act, is_ref, is_rd, is_wr;

    assign dq     = dq_oe ? dq_out : 16'hzzzz;
    assign cmd    = {pins.n_ras, pins.n_cas, pins.n_we};
    assign valid  = !pins.n_cs && pins.cke;
    assign is_act = valid && cmd == 3'b011;
    assign is_ref = valid && cmd == 3'b001;
    assign is_rd  = valid && cmd == 3'b101;
    assign is_wr  = valid && cmd == 3'b100;

    function automatic logic [15:0] word_at(input int key);
        return mem.exists(key) ? mem[key] : 16'hxxxx;
    endfunction

    always @(posedge clk) begin
        logic [15:0] old;
        int          key;
        since_rc  <= (is_act || is_ref) ? 1 : since_rc + 1;
        since_act <= is_act ? 1 : since_act + 1;
        if (is_ref) refresh_count <= refresh_count + 1;
        if (is_act) row_open[pins.ba] <= pins.a;
        if (is_wr) begin
            key = int'({row_open[pins.ba], pins.a[8:0]});
            old = mem.exists(key) ? mem[key] : 16'h0000;
            mem[key] = {pins.dqmh ? old[15:8] : dq[15:8], pins.dqml ? old[7:0] : dq[7:0]};
        end
        // CL2 burst of two, first word one cycle before the sample edge
        case (rd_stage)
            2'd1: begin
                dq_out   <= word_at(int'({row_open[rd_ba], rd_col}));
                dq_oe    <= 1'b1;
                rd_stage <= 2'd2;
            end
            2'd2: begin
                dq_out   <= word_at(int'({row_open[rd_ba], rd_col + 9'd1}));
                rd_stage <= 2'd3;
            end
            2'd3: begin
                dq_oe    <= 1'b0;
                rd_stage <= 2'd0;
            end
            default: ;
        endcase
        if (is_rd) begin
            rd_ba    <= pins.ba;
            rd_col   <= pins.a[8:0];
            rd_stage <= 2'd1;
        end
    end

    assert property (@(posedge clk) (is_act || is_ref) |-> since_rc >= jtframe_pkg::T_RC)
        else begin
            $display("SDRAM model at %0t: row command only %0d cycles after the last one",
                     $time, since_rc);
            errors++;
        end
    assert property (@(posedge clk) (is_rd || is_wr) |-> since_act >= jtframe_pkg::T_RCD)
        else begin
            $display("SDRAM model at %0t: column command too soon after ACTIVE", $time);
            errors++;
        end

endmodule

// ==== logic/jtframe_mister.sv ====
`timescale 1ns/1ps

module jtframe_mister #(
    parameter bit THREE_BUTTONS          = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1,
    parameter int INIT_WAIT              = 9600
) (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  jtframe_pkg::hps_bus_t   hps_bus,
    output jtframe_pkg::status_t    status,
    // ROM download
    output logic                    downloading,
    output logic [21:0]             ioctl_addr,
    output logic [7:0]              ioctl_data,
    output logic                    ioctl_wr,
    input  logic [21:0]             prog_addr,
    input  logic [7:0]              prog_data,
    input  logic [1:0]              prog_mask,
    input  logic                    prog_we,
    // Game ROM access
    input  logic                    sdram_req,
    output logic                    sdram_ack,
    input  logic [21:0]             sdram_addr,
    output logic [31:0]             data_read,
    output logic                    data_rdy,
    output logic                    loop_rst,
    input  logic                    refresh_en,
    // Board
    input  logic                    rst_req,
    output logic                    game_rst,
    output logic [6:0]              game_joystick1,
    output logic [6:0]              game_joystick2,
    output logic [1:0]              game_coin,
    output logic [1:0]              game_start,
    output jtframe_pkg::dip_t       dip,
    output jtframe_pkg::sdram_pins_t sdram_pins,
    inout  wire  [15:0]             sdram_dq,
    output logic                    led
);

    logic [9:0] joystick1, joystick2;

    assign led = downloading;   // Lit while the ROM loads

    jtframe_hps_io u_hps_io (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .hps_bus     ( hps_bus     ),
        .status      ( status      ),
        .joystick1   ( joystick1   ),
        .joystick2   ( joystick2   ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    )
    );

    jtframe_board #(
        .THREE_BUTTONS          ( THREE_BUTTONS          ),
        .GAME_INPUTS_ACTIVE_LOW ( GAME_INPUTS_ACTIVE_LOW ),
        .INIT_WAIT              ( INIT_WAIT              )
    ) u_board (
        .clk_sys         ( clk_sys        ),
        .rst_n           ( rst_n          ),
        .rst_req         ( rst_req        ),
        .downloading     ( downloading    ),
        .status          ( status         ),
        .board_joystick1 ( joystick1      ),
        .board_joystick2 ( joystick2      ),
        .game_rst        ( game_rst       ),
        .dip             ( dip            ),
        .game_joystick1  ( game_joystick1 ),
        .game_joystick2  ( game_joystick2 ),
        .game_coin       ( game_coin      ),
        .game_start      ( game_start     ),
        .sdram_req       ( sdram_req      ),
        .sdram_addr      ( sdram_addr     ),
        .refresh_en      ( refresh_en     ),
        .prog_addr       ( prog_addr      ),
        .prog_data       ( prog_data      ),
        .prog_mask       ( prog_mask      ),
        .prog_we         ( prog_we        ),
        .sdram_pins      ( sdram_pins     ),
        .sdram_dq        ( sdram_dq       ),
        .sdram_ack       ( sdram_ack      ),
        .data_read       ( data_read      ),
        .data_rdy        ( data_rdy       ),
        .loop_rst        ( loop_rst       )
    );

endmodule

// ==== logic/jtframe_hps_io.sv ====
`timescale 1ns/1ps

module jtframe_hps_io (
    input  logic                 clk_sys,
    input  logic                 rst_n,
    input  jtframe_pkg::hps_bus_t hps_bus,
    output jtframe_pkg::status_t status,
    output logic [9:0]           joystick1,
    output logic [9:0]           joystick2,
    output logic                 downloading,
    output logic [21:0]          ioctl_addr,
    output logic [7:0]           ioctl_data,
    output logic                 ioctl_wr
);

    typedef enum logic {
        ST_CMD,     // Next strobe is the command code
        ST_DATA     // Payload words
    } st_t;

    st_t        st;
    logic [7:0] cmd;
    logic       word_idx;       // Second payload word seen
    logic [15:0] status_lo;
    logic       data_stb;

    assign data_stb = hps_bus.io_enable && hps_bus.io_strobe && st == ST_DATA;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            st          <= ST_CMD;
            cmd         <= '0;
            word_idx    <= 1'b0;
            status      <= '0;
            joystick1   <= '0;
            joystick2   <= '0;
            downloading <= 1'b0;
            ioctl_addr  <= '0;
            ioctl_wr    <= 1'b0;
        end else begin
            ioctl_wr <= 1'b0;
            if (ioctl_wr) ioctl_addr <= ioctl_addr + 22'd1;
            if (!hps_bus.io_enable) begin
                st <= ST_CMD;   // Frame closed
            end else if (hps_bus.io_strobe) begin
                case (st)
                    ST_CMD: begin
                        cmd      <= hps_bus.io_din[7:0];
                        word_idx <= 1'b0;
                        st       <= ST_DATA;
                        if (hps_bus.io_din[7:0] == jtframe_pkg::CMD_DL_START) begin
                            downloading <= 1'b1;
                            ioctl_addr  <= '0;
                        end
                        if (hps_bus.io_din[7:0] == jtframe_pkg::CMD_DL_END)
                            downloading <= 1'b0;
                    end
                    ST_DATA: begin
                        word_idx <= 1'b1;
                        case (cmd)
                            jtframe_pkg::CMD_JOY0: joystick1 <= hps_bus.io_din[9:0];
                            jtframe_pkg::CMD_JOY1: joystick2 <= hps_bus.io_din[9:0];
                            jtframe_pkg::CMD_STATUS: begin
                                if (word_idx)
                                    status <= {hps_bus.io_din, status_lo};
                            end
                            jtframe_pkg::CMD_DL_START: ioctl_wr <= 1'b1;
                            default: ;
                        endcase
                    end
                    default: st <= ST_CMD;
                endcase
            end
        end
    end

    // Payload words held until used
    always_ff @(posedge clk_sys) begin
        if (data_stb && cmd == jtframe_pkg::CMD_STATUS && !word_idx)
            status_lo <= hps_bus.io_din;    // Low half first
        if (data_stb && cmd == jtframe_pkg::CMD_DL_START)
            ioctl_data <= hps_bus.io_din[7:0];
    end

    // Writes cannot leak past the end of a download
    assert property (@(posedge clk_sys) disable iff (!rst_n) ioctl_wr |-> downloading);

endmodule

// ==== logic/jtframe_board.sv ====
`timescale 1ns/1ps

module jtframe_board #(
    parameter bit THREE_BUTTONS          = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1,
    parameter int INIT_WAIT              = 9600
) (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  logic                    rst_req,
    input  logic                    downloading,
    input  jtframe_pkg::status_t    status,
    input  logic [9:0]              board_joystick1,
    input  logic [9:0]              board_joystick2,
    output logic                    game_rst,
    output jtframe_pkg::dip_t       dip,
    output logic [6:0]              game_joystick1,
    output logic [6:0]              game_joystick2,
    output logic [1:0]              game_coin,
    output logic [1:0]              game_start,
    // SDRAM
    input  logic                    sdram_req,
    input  logic [21:0]             sdram_addr,
    input  logic                    refresh_en,
    input  logic [21:0]             prog_addr,
    input  logic [7:0]              prog_data,
    input  logic [1:0]              prog_mask,
    input  logic                    prog_we,
    output jtframe_pkg::sdram_pins_t sdram_pins,
    inout  wire  [15:0]             sdram_dq,
    output logic                    sdram_ack,
    output logic [31:0]             data_read,
    output logic                    data_rdy,
    output logic                    loop_rst
);

    logic       flip_last;
    logic       rst_cause;
    logic [3:0] rst_cnt;
    logic [1:0] coin_raw, start_raw;

    // Directions and buttons, polarity applied last
    function automatic logic [6:0] map_joy(input logic [9:0] raw);
        logic [6:0] joy;
        joy = {THREE_BUTTONS ? raw[6] : 1'b0, raw[5:0]};
        return GAME_INPUTS_ACTIVE_LOW ? ~joy : joy;
    endfunction

    assign game_joystick1 = map_joy(board_joystick1);
    assign game_joystick2 = map_joy(board_joystick2);
    assign coin_raw       = {board_joystick2[8], board_joystick1[8]};
    assign start_raw      = {board_joystick2[9], board_joystick1[9]};
    assign game_coin      = GAME_INPUTS_ACTIVE_LOW ? ~coin_raw : coin_raw;
    assign game_start     = GAME_INPUTS_ACTIVE_LOW ? ~start_raw : start_raw;

    // A flip change restarts the game too
    assign rst_cause = loop_rst || downloading || rst_req || status.reset ||
                       (status.flip != flip_last);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            dip       <= '0;
            flip_last <= 1'b0;
            game_rst  <= 1'b1;
            rst_cnt   <= '0;
        end else begin
            dip.test         <= status.test;
            dip.pause        <= status.pause;
            dip.flip         <= status.flip;
            dip.service      <= status.service;
            dip.fxlevel      <= status.fxlevel;
            dip.scanlines    <= status.scanlines;
            dip.force_scan2x <= status.force_scan2x;
            dip.rotate       <= status.rotate;
            dip.en_mixing    <= status.en_mixing;
            flip_last        <= status.flip;
            if (rst_cause) begin
                game_rst <= 1'b1;
                rst_cnt  <= '0;
            end else if (game_rst) begin
                rst_cnt <= rst_cnt + 4'd1;
                if (rst_cnt == 4'd15) game_rst <= 1'b0;  // 16 quiet cycles
            end
        end
    end

    jtframe_sdram #(.INIT_WAIT(INIT_WAIT)) u_sdram (
        .clk_sys    ( clk_sys    ),
        .rst_n      ( rst_n      ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .refresh_en ( refresh_en ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prog_we    ( prog_we    ),
        .sdram_ack  ( sdram_ack  ),
        .data_read  ( data_read  ),
        .data_rdy   ( data_rdy   ),
        .loop_rst   ( loop_rst   ),
        .sdram_pins ( sdram_pins ),
        .sdram_dq   ( sdram_dq   )
    );

    assert property (@(posedge clk_sys) disable iff (!rst_n) loop_rst |-> game_rst);

endmodule

// ==== logic/jtframe_sdram.sv ====
`timescale 1ns/1ps

module jtframe_sdram #(
    parameter int INIT_WAIT = 9600
) (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  logic                    sdram_req,
    input  logic [21:0]             sdram_addr,     // Word address
    input  logic                    refresh_en,
    input  logic [21:0]             prog_addr,      // Byte address
    input  logic [7:0]              prog_data,
    input  logic [1:0]              prog_mask,      // Active low
    input  logic                    prog_we,
    output logic                    sdram_ack,
    output logic [31:0]             data_read,
    output logic                    data_rdy,
    output logic                    loop_rst,
    output jtframe_pkg::sdram_pins_t sdram_pins,
    inout  wire  [15:0]             sdram_dq
);

    // {n_ras, n_cas, n_we}
    localparam logic [2:0] CMD_NOP = 3'b111;
    localparam logic [2:0] CMD_ACT = 3'b011;
    localparam logic [2:0] CMD_RD  = 3'b101;
    localparam logic [2:0] CMD_WR  = 3'b100;
    localparam logic [2:0] CMD_PRE = 3'b010;
    localparam logic [2:0] CMD_REF = 3'b001;
    localparam logic [2:0] CMD_MRS = 3'b000;

    // Burst 2 reads, single writes, CL2
    localparam logic [12:0] MODE_REG = {3'b000, 1'b1, 2'b00,
                                        3'(jtframe_pkg::CAS_LAT), 1'b0, 3'b001};

    localparam int INIT_REF1 = INIT_WAIT + 2;
    localparam int INIT_REF2 = INIT_REF1 + jtframe_pkg::T_RC;
    localparam int INIT_MRS  = INIT_REF2 + jtframe_pkg::T_RC;
    localparam int INIT_DONE = INIT_MRS + 2;
    localparam int IW        = $clog2(INIT_DONE + 1);
    localparam int RW        = $clog2(jtframe_pkg::REFRESH_PERIOD);

    localparam logic [3:0] CAS_AT = 4'(jtframe_pkg::T_RCD);
    localparam logic [3:0] RD_LO  = 4'(jtframe_pkg::T_RCD + jtframe_pkg::CAS_LAT + 1);
    localparam logic [3:0] RD_HI  = RD_LO + 4'd1;
    localparam logic [3:0] LAST   = 4'(jtframe_pkg::T_RC - 1);

    typedef enum logic [1:0] {ST_INIT, ST_IDLE, ST_BUSY} st_t;
    typedef enum logic [1:0] {OP_RD, OP_WR, OP_REF} op_t;

    st_t            st;
    op_t            op;
    logic [3:0]     cnt;            // Cycle index within an access
    logic [IW-1:0]  init_cnt;
    logic [RW-1:0]  ref_timer;
    logic           refresh_owed;
    logic           wr_pend;
    logic           dq_oe;
    logic [21:0]    wr_addr, next_addr, acc_addr;
    logic [7:0]     wr_data;
    logic [1:0]     wr_mask;
    logic [15:0]    rd_lo;

    assign next_addr = wr_pend ? wr_addr : sdram_addr;
    assign sdram_dq  = dq_oe ? {wr_data, wr_data} : 16'hzzzz;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            st           <= ST_INIT;
            op           <= OP_REF;
            cnt          <= '0;
            init_cnt     <= '0;
            ref_timer    <= '0;
            refresh_owed <= 1'b0;
            wr_pend      <= 1'b0;
            dq_oe        <= 1'b0;
            loop_rst     <= 1'b1;
            sdram_ack    <= 1'b0;
            data_rdy     <= 1'b0;
            sdram_pins   <= '{a: '0, ba: '0, dqml: 1'b1, dqmh: 1'b1, n_we: 1'b1,
                              n_cas: 1'b1, n_ras: 1'b1, n_cs: 1'b1, cke: 1'b0};
        end else begin
            {sdram_pins.n_ras, sdram_pins.n_cas, sdram_pins.n_we} <= CMD_NOP;
            sdram_pins.dqml <= 1'b0;
            sdram_pins.dqmh <= 1'b0;
            sdram_ack       <= 1'b0;
            data_rdy        <= 1'b0;
            dq_oe           <= 1'b0;
            case (st)
                ST_INIT: begin
                    sdram_pins.cke  <= 1'b1;
                    sdram_pins.n_cs <= 1'b0;
                    init_cnt        <= init_cnt + 1'b1;
                    if (init_cnt == IW'(INIT_WAIT)) begin
                        {sdram_pins.n_ras, sdram_pins.n_cas, sdram_pins.n_we} <= CMD_PRE;
                        sdram_pins.a[10] <= 1'b1;   // All banks
                    end
                    if (init_cnt == IW'(INIT_REF1) || init_cnt == IW'(INIT_REF2))
                        {sdram_pins.n_ras, sdram_pins.n_cas, sdram_pins.n_we} <= CMD_REF;
                    if (init_cnt == IW'(INIT_MRS)) begin
                        {sdram_pins.n_ras, sdram_pins.n_cas, sdram_pins.n_we} <= CMD_MRS;
                        sdram_pins.a  <= MODE_REG;
                        sdram_pins.ba <= 2'b00;
                    end
                    if (init_cnt == IW'(INIT_DONE)) begin
                        loop_rst <= 1'b0;
                        st       <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    cnt <= 4'd1;
                    if (wr_pend || sdram_req) begin
                        // Writes first, reads wait behind refresh
                        if (wr_pend || !(refresh_owed && refresh_en)) begin
                            {sdram_pins.n_ras, sdram_pins.n_cas, sdram_pins.n_we} <= CMD_ACT;
                            sdram_pins.a  <= next_addr[21:9];
                            sdram_pins.ba <= next_addr[21:20];
                            st            <= ST_BUSY;
                            op            <= wr_pend ? OP_WR : OP_RD;
                            wr_pend       <= 1'b0;
                            sdram_ack     <= !wr_pend;
                        end
                    end
                    if (!wr_pend && refresh_owed && refresh_en) begin
                        {sdram_pins.n_ras, sdram_pins.n_cas, sdram_pins.n_we} <= CMD_REF;
                        st           <= ST_BUSY;
                        op           <= OP_REF;
                        refresh_owed <= 1'b0;
                    end
                end
                default: begin  // ST_BUSY
                    cnt <= cnt + 4'd1;
                    if (cnt == CAS_AT && op != OP_REF) begin
                        {sdram_pins.n_ras, sdram_pins.n_cas, sdram_pins.n_we} <=
                            op == OP_WR ? CMD_WR : CMD_RD;
                        sdram_pins.a <= {2'b00, 1'b1, 1'b0, acc_addr[8:0]};  // Auto precharge
                        if (op == OP_WR) begin
                            dq_oe           <= 1'b1;
                            sdram_pins.dqml <= wr_mask[0];
                            sdram_pins.dqmh <= wr_mask[1];
                        end
                    end
                    if (op == OP_RD && cnt == RD_HI) data_rdy <= 1'b1;
                    if (cnt == LAST) st <= ST_IDLE;     // T_RC met
                end
            endcase
            if (st != ST_INIT) begin
                ref_timer <= ref_timer + 1'b1;
                if (ref_timer == RW'(jtframe_pkg::REFRESH_PERIOD - 1)) begin
                    ref_timer    <= '0;
                    refresh_owed <= 1'b1;
                end
            end
            if (prog_we) wr_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (prog_we) begin
            wr_addr <= {1'b0, prog_addr[21:1]};     // Byte to word
            wr_data <= prog_data;
            wr_mask <= prog_mask;
        end
        if (st == ST_IDLE) acc_addr <= next_addr;
        if (st == ST_BUSY && op == OP_RD && cnt == RD_LO) rd_lo <= sdram_dq;
        if (st == ST_BUSY && op == OP_RD && cnt == RD_HI)
            data_read <= {sdram_dq, rd_lo};
    end

    assert property (@(posedge clk_sys) disable iff (!rst_n) sdram_ack |-> !loop_rst);
    assert property (@(posedge clk_sys) disable iff (!rst_n) sdram_req |-> !sdram_addr[0]);

endmodule

// ==== logic/jtframe_pkg.sv ====
package jtframe_pkg;

    // Host command codes, first strobe of a frame
    localparam logic [7:0] CMD_JOY0     = 8'h01;
    localparam logic [7:0] CMD_JOY1     = 8'h02;
    localparam logic [7:0] CMD_STATUS   = 8'h1e;
    localparam logic [7:0] CMD_DL_START = 8'h10;
    localparam logic [7:0] CMD_DL_END   = 8'h11;

    typedef struct packed {
        logic        io_enable;     // Frames one command
        logic        io_strobe;     // One cycle per word
        logic [15:0] io_din;
    } hps_bus_t;

    // Menu and DIP settings as sent by the host
    typedef struct packed {
        logic [17:0] spare;
        logic        en_mixing;
        logic [1:0]  rotate;
        logic        force_scan2x;
        logic [2:0]  scanlines;
        logic [1:0]  fxlevel;
        logic        service;
        logic        pause;
        logic        test;
        logic        flip;
        logic        reset;
    } status_t;

    typedef struct packed {
        logic       test;
        logic       pause;
        logic       flip;
        logic       service;
        logic [1:0] fxlevel;
        logic [2:0] scanlines;
        logic       force_scan2x;
        logic [1:0] rotate;
        logic       en_mixing;
    } dip_t;

    typedef struct packed {
        logic [12:0] a;
        logic [1:0]  ba;
        logic        dqml;
        logic        dqmh;
        logic        n_we;
        logic        n_cas;
        logic        n_ras;
        logic        n_cs;
        logic        cke;
    } sdram_pins_t;

    // SDRAM timing in clk_sys cycles
    localparam int T_RCD          = 2;
    localparam int CAS_LAT        = 2;
    localparam int T_RC           = 7;
    localparam int REFRESH_PERIOD = 64;

endpackage
